//--- Bender.yml
package:
  name: ccip_sniffer

sources:
  - files:
      - hw/ccip_check_pkg.sv
      - hw/c0_read_checker.sv
      - hw/c1_write_checker.sv
      - hw/mmio_rsp_tracker.sv
      - hw/ccip_sniffer.sv
  - target: test
    files:
      - verification/ccip_sniffer_properties.sv
      - verification/tb_ccip_sniffer.sv

//--- files.f
hw/ccip_check_pkg.sv
hw/c0_read_checker.sv
hw/c1_write_checker.sv
hw/mmio_rsp_tracker.sv
hw/ccip_sniffer.sv
verification/ccip_sniffer_properties.sv
verification/tb_ccip_sniffer.sv

//--- hw/c0_read_checker.sv
// Channel 0 read request rules
`timescale 1ns/10ps

module c0_read_checker (
   input  ccip_check_pkg::c0_req_t                  c0_tx,
   input  logic                                     c0_full,
   output logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] flags
);

   logic is_read;
   logic rd_valid;
   logic len_2;
   logic len_4;

   // Only the two read opcodes are legal here
   assign is_read = c0_tx.req_type inside {ccip_check_pkg::REQ_RDLINE_I,
                                           ccip_check_pkg::REQ_RDLINE_S};

   // Header rules apply to legal reads only
   assign rd_valid = c0_tx.valid && is_read;

   assign len_2 = (c0_tx.cl_len == ccip_check_pkg::CL_LEN_2);
   assign len_4 = (c0_tx.cl_len == ccip_check_pkg::CL_LEN_4);

   always_comb begin
      flags = '0;

      // Opcode outside the read set
      flags[ccip_check_pkg::C0TX_INVALID_REQTYPE] = c0_tx.valid && !is_read;

      // Request pushed into a full channel
      flags[ccip_check_pkg::C0TX_OVERFLOW] = c0_tx.valid && c0_full;

      // 3-line reads do not exist
      flags[ccip_check_pkg::C0TX_3CL_REQUEST] =
         rd_valid && (c0_tx.cl_len == ccip_check_pkg::CL_LEN_3);

      // 2-line burst needs an even line address
      flags[ccip_check_pkg::C0TX_ADDRALIGN_2] = rd_valid && len_2 && c0_tx.address[0];

      // 4-line burst needs both low bits clear
      flags[ccip_check_pkg::C0TX_ADDRALIGN_4] =
         rd_valid && len_4 && (c0_tx.address[1:0] != 2'b00);

      // Line zero is almost always a bad pointer
      flags[ccip_check_pkg::C0TX_ADDR_ZERO_WARN] = rd_valid && (c0_tx.address == '0);
   end

endmodule

//--- hw/c1_write_checker.sv
// Channel 1 write request rules and burst tracker
`timescale 1ns/10ps

module c1_write_checker (
   input  logic                                     clk,
   input  logic                                     ase_reset,
   input  logic                                     soft_reset,
   input  ccip_check_pkg::c1_req_t                  c1_tx,
   input  logic                                     c1_full,
   output logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] flags
);

   ccip_check_pkg::mcl_state_e state;
   ccip_check_pkg::mcl_state_e state_next;

   // First-beat header, held for the rest of the burst
   logic [1:0]                             base_addr_low2;
   logic [ccip_check_pkg::VC_SEL_W-1:0]    base_vc;
   ccip_check_pkg::cl_len_e                base_len;
   logic [ccip_check_pkg::MDATA_W-1:0]     base_mdata;

   logic       is_write;
   logic       is_fence;
   logic       multi_line;
   logic       last_beat;
   logic [1:0] beat_num;
   logic [1:0] exp_addr_low2;

   assign is_write = c1_tx.valid && (c1_tx.req_type inside {ccip_check_pkg::REQ_WRLINE_I,
                                                            ccip_check_pkg::REQ_WRLINE_M,
                                                            ccip_check_pkg::REQ_WRPUSH_I});
   assign is_fence = c1_tx.valid && (c1_tx.req_type == ccip_check_pkg::REQ_WRFENCE);

   // Only 2 and 4 line writes open a burst
   assign multi_line = (c1_tx.cl_len == ccip_check_pkg::CL_LEN_2) ||
                       (c1_tx.cl_len == ccip_check_pkg::CL_LEN_4);

   // State encoding doubles as beat count from zero
   assign beat_num      = state;
   assign exp_addr_low2 = base_addr_low2 + beat_num;

   // Burst ends on beat 2 of a 2-line or beat 4 of a 4-line write
   assign last_beat = (state == ccip_check_pkg::EXP_FOURTH) ||
                      ((state == ccip_check_pkg::EXP_SECOND) &&
                       (base_len == ccip_check_pkg::CL_LEN_2));

   always_comb begin
      flags      = '0;
      state_next = state;

      // Rules that hold in every state
      flags[ccip_check_pkg::C1TX_INVALID_REQTYPE] = c1_tx.valid && !is_write && !is_fence;
      flags[ccip_check_pkg::C1TX_OVERFLOW]        = c1_tx.valid && c1_full;

      if (state == ccip_check_pkg::EXP_FIRST) begin
         // Header checks on a fresh write
         flags[ccip_check_pkg::C1TX_SOP_NOT_SET] = is_write && !c1_tx.sop;
         flags[ccip_check_pkg::C1TX_3CL_REQUEST] =
            is_write && (c1_tx.cl_len == ccip_check_pkg::CL_LEN_3);
         flags[ccip_check_pkg::C1TX_ADDRALIGN_2] = is_write && c1_tx.address[0] &&
            (c1_tx.cl_len == ccip_check_pkg::CL_LEN_2);
         flags[ccip_check_pkg::C1TX_ADDRALIGN_4] = is_write &&
            (c1_tx.cl_len == ccip_check_pkg::CL_LEN_4) && (c1_tx.address[1:0] != 2'b00);
         flags[ccip_check_pkg::C1TX_ADDR_ZERO_WARN] = is_write && (c1_tx.address == '0);

         // Fence or single line stays here
         if (is_write && multi_line) begin
            state_next = ccip_check_pkg::EXP_SECOND;
         end
      end else begin
         // Fence inside a burst, burst position is kept
         flags[ccip_check_pkg::C1TX_WRFENCE_IN_MCL] = is_fence;

         // Later beats must match the first one
         flags[ccip_check_pkg::C1TX_SOP_SET_MCL] = is_write && c1_tx.sop;
         flags[ccip_check_pkg::C1TX_UNEXP_ADDR]  =
            is_write && (c1_tx.address[1:0] != exp_addr_low2);
         flags[ccip_check_pkg::C1TX_UNEXP_VCSEL] = is_write && (c1_tx.vc_sel != base_vc);
         flags[ccip_check_pkg::C1TX_UNEXP_CLLEN] = is_write && (c1_tx.cl_len != base_len);
         flags[ccip_check_pkg::C1TX_UNEXP_MDATA] = is_write && (c1_tx.mdata != base_mdata);

         if (is_write) begin
            if (last_beat) begin
               state_next = ccip_check_pkg::EXP_FIRST;
            end else begin
               state_next = ccip_check_pkg::mcl_state_e'(state + 2'd1);
            end
         end
      end
   end

   // Burst position
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset) begin
         state <= ccip_check_pkg::EXP_FIRST;
      end else begin
         state <= state_next;
      end
   end

   // Capture reference header on each first beat
   always_ff @(posedge clk) begin
      if ((state == ccip_check_pkg::EXP_FIRST) && is_write) begin
         base_addr_low2 <= c1_tx.address[1:0];
         base_vc        <= c1_tx.vc_sel;
         base_len       <= c1_tx.cl_len;
         base_mdata     <= c1_tx.mdata;
      end
   end

endmodule

//--- hw/ccip_check_pkg.sv
// CCI-P checker definitions
package ccip_check_pkg;

   // Field widths
   localparam int CL_ADDR_W  = 42;
   localparam int MDATA_W    = 16;
   localparam int VC_SEL_W   = 2;
   localparam int MMIO_TID_W = 4;

   // One tracker entry per MMIO TID
   localparam int MMIO_TIDS = 2 ** MMIO_TID_W;

   // Cycles an MMIO read may stay unanswered
   localparam int MMIO_RSP_TIMEOUT = 64;
   // Saturating timer must reach the timeout value
   localparam int MMIO_TIMER_W = $clog2(MMIO_RSP_TIMEOUT + 1);

   // One bit per rule, fence-in-burst takes the top bit
   localparam int SNIFF_VECTOR_W = 21;

   // Channel 0 opcodes, any other code is illegal
   typedef enum logic [3:0] {
      REQ_RDLINE_I = 4'h0,
      REQ_RDLINE_S = 4'h1
   } c0_req_e;

   // Channel 1 opcodes
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h0,
      REQ_WRLINE_M = 4'h1,
      REQ_WRPUSH_I = 4'h2,
      REQ_WRFENCE  = 4'h4
   } c1_req_e;

   // Burst length field
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_3 = 2'b10,
      CL_LEN_4 = 2'b11
   } cl_len_e;

   // Next write beat expected, encoding equals beat number
   typedef enum logic [1:0] {
      EXP_FIRST  = 2'd0,
      EXP_SECOND = 2'd1,
      EXP_THIRD  = 2'd2,
      EXP_FOURTH = 2'd3
   } mcl_state_e;

   // Bit position of each violation in error_code
   typedef enum logic [4:0] {
      C0TX_INVALID_REQTYPE   = 5'd0,
      C0TX_OVERFLOW          = 5'd1,
      C0TX_3CL_REQUEST       = 5'd2,
      C0TX_ADDRALIGN_2       = 5'd3,
      C0TX_ADDRALIGN_4       = 5'd4,
      C0TX_ADDR_ZERO_WARN    = 5'd5,
      C1TX_INVALID_REQTYPE   = 5'd6,
      C1TX_OVERFLOW          = 5'd7,
      C1TX_3CL_REQUEST       = 5'd8,
      C1TX_ADDRALIGN_2       = 5'd9,
      C1TX_ADDRALIGN_4       = 5'd10,
      C1TX_ADDR_ZERO_WARN    = 5'd11,
      C1TX_SOP_NOT_SET       = 5'd12,
      C1TX_SOP_SET_MCL       = 5'd13,
      C1TX_UNEXP_ADDR        = 5'd14,
      C1TX_UNEXP_VCSEL       = 5'd15,
      C1TX_UNEXP_CLLEN       = 5'd16,
      C1TX_UNEXP_MDATA       = 5'd17,
      MMIO_RDRSP_TIMEOUT     = 5'd18,
      MMIO_RDRSP_UNSOLICITED = 5'd19,
      C1TX_WRFENCE_IN_MCL    = 5'd20
   } sniff_code_e;

   // Channel 0 read request
   typedef struct packed {
      logic                 valid;
      c0_req_e              req_type;
      cl_len_e              cl_len;
      logic [VC_SEL_W-1:0]  vc_sel;
      logic [CL_ADDR_W-1:0] address;
      logic [MDATA_W-1:0]   mdata;
   } c0_req_t;

   // Channel 1 write request
   typedef struct packed {
      logic                 valid;
      c1_req_e              req_type;
      cl_len_e              cl_len;
      logic [VC_SEL_W-1:0]  vc_sel;
      logic                 sop;
      logic [CL_ADDR_W-1:0] address;
      logic [MDATA_W-1:0]   mdata;
   } c1_req_t;

   // MMIO read request or response
   typedef struct packed {
      logic                  valid;
      logic [MMIO_TID_W-1:0] tid;
   } mmio_evt_t;

endpackage

//--- hw/ccip_sniffer.sv
// CCI-P protocol checker top
`timescale 1ns/10ps

module ccip_sniffer (
   input  logic                                     clk,
   input  logic                                     ase_reset,
   input  logic                                     soft_reset,
   input  ccip_check_pkg::c0_req_t                  c0_tx,
   input  ccip_check_pkg::c1_req_t                  c1_tx,
   input  logic                                     c0_full,
   input  logic                                     c1_full,
   input  ccip_check_pkg::mmio_evt_t                mmio_req,
   input  ccip_check_pkg::mmio_evt_t                mmio_rsp,
   output logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] error_code
);

   // Each checker sets only its own bits
   logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] c0_flags;
   logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] c1_flags;
   logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] mmio_flags;

   // Read request rules
   c0_read_checker u_c0_read_checker (
      .c0_tx   (c0_tx),
      .c0_full (c0_full),
      .flags   (c0_flags)
   );

   // Write request rules and burst tracking
   c1_write_checker u_c1_write_checker (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c1_tx      (c1_tx),
      .c1_full    (c1_full),
      .flags      (c1_flags)
   );

   // MMIO read response tracking
   mmio_rsp_tracker u_mmio_rsp_tracker (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .flags      (mmio_flags)
   );

   // One cycle after the violation, either reset clears
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset) begin
         error_code <= '0;
      end else begin
         error_code <= c0_flags | c1_flags | mmio_flags;
      end
   end

endmodule

//--- hw/mmio_rsp_tracker.sv
// Outstanding MMIO read tracker
`timescale 1ns/10ps

module mmio_rsp_tracker (
   input  logic                                     clk,
   input  logic                                     ase_reset,
   input  logic                                     soft_reset,
   input  ccip_check_pkg::mmio_evt_t                mmio_req,
   input  ccip_check_pkg::mmio_evt_t                mmio_rsp,
   output logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] flags
);

   // One slot per TID
   logic [ccip_check_pkg::MMIO_TIDS-1:0]    active;
   logic [ccip_check_pkg::MMIO_TIMER_W-1:0] timer [ccip_check_pkg::MMIO_TIDS];
   logic [ccip_check_pkg::MMIO_TIDS-1:0]    timed_out;

   for (genvar i = 0; i < ccip_check_pkg::MMIO_TIDS; i++) begin : g_entry
      logic req_hit;
      logic rsp_hit;
      logic at_limit;

      assign req_hit = mmio_req.valid && (mmio_req.tid == ccip_check_pkg::MMIO_TID_W'(i));
      assign rsp_hit = mmio_rsp.valid && (mmio_rsp.tid == ccip_check_pkg::MMIO_TID_W'(i));

      assign at_limit = (timer[i] ==
                         ccip_check_pkg::MMIO_TIMER_W'(ccip_check_pkg::MMIO_RSP_TIMEOUT));

      // Waiting too long for an answer
      assign timed_out[i] = active[i] && at_limit;

      // New request wins over a response in the same cycle
      always_ff @(posedge clk) begin
         if (ase_reset || soft_reset) begin
            active[i] <= 1'b0;
         end else if (req_hit) begin
            active[i] <= 1'b1;
         end else if (rsp_hit) begin
            active[i] <= 1'b0;
         end
      end

      // Counts cycles since the request, saturates at the limit
      always_ff @(posedge clk) begin
         if (req_hit) begin
            timer[i] <= '0;
         end else if (active[i] && !at_limit) begin
            timer[i] <= timer[i] + 1'b1;
         end
      end
   end

   always_comb begin
      flags = '0;

      // Response with nothing outstanding on that TID
      flags[ccip_check_pkg::MMIO_RDRSP_UNSOLICITED] = mmio_rsp.valid && !active[mmio_rsp.tid];

      // Any slot past its deadline
      flags[ccip_check_pkg::MMIO_RDRSP_TIMEOUT] = |timed_out;
   end

endmodule

//--- verification/ccip_sniffer_properties.sv
// CCI-P checker properties
`timescale 1ns/10ps

module ccip_sniffer_properties (
   input logic                                      clk,
   input logic                                      ase_reset,
   input logic                                      soft_reset,
   input ccip_check_pkg::c0_req_t                   c0_tx,
   input ccip_check_pkg::c1_req_t                   c1_tx,
   input logic                                      c0_full,
   input logic                                      c1_full,
   input logic [ccip_check_pkg::SNIFF_VECTOR_W-1:0] error_code
);

   int   fail_count = 0;
   logic rd_req;

   // Valid request with one of the two read opcodes
   assign rd_req = c0_tx.valid && ((c0_tx.req_type == ccip_check_pkg::REQ_RDLINE_I) ||
                                   (c0_tx.req_type == ccip_check_pkg::REQ_RDLINE_S));

   // Read overflow bit mirrors the previous cycle unless a soft reset cleared it
   c0_overflow: assert property (@(posedge clk) disable iff (ase_reset || soft_reset)
      !soft_reset |=> (error_code[ccip_check_pkg::C0TX_OVERFLOW] ==
                       $past(c0_tx.valid && c0_full)))
   else begin
      fail_count++;
      $error("read overflow bit does not follow a request into a full channel");
   end

   // Same for the write channel
   c1_overflow: assert property (@(posedge clk) disable iff (ase_reset || soft_reset)
      !soft_reset |=> (error_code[ccip_check_pkg::C1TX_OVERFLOW] ==
                       $past(c1_tx.valid && c1_full)))
   else begin
      fail_count++;
      $error("write overflow bit does not follow a request into a full channel");
   end

   c0_three_line: assert property (@(posedge clk) disable iff (ase_reset || soft_reset)
      !soft_reset |=> (error_code[ccip_check_pkg::C0TX_3CL_REQUEST] ==
                       $past(rd_req && (c0_tx.cl_len == ccip_check_pkg::CL_LEN_3))))
   else begin
      fail_count++;
      $error("3-line read bit does not match the request length");
   end

   // Line zero on a read
   c0_zero_addr: assert property (@(posedge clk) disable iff (ase_reset || soft_reset)
      !soft_reset |=> (error_code[ccip_check_pkg::C0TX_ADDR_ZERO_WARN] ==
                       $past(rd_req && (c0_tx.address == '0))))
   else begin
      fail_count++;
      $error("zero address bit does not match the read address");
   end

   // Nothing reported in the cycle after a soft reset
   soft_reset_clears: assert property (@(posedge clk) disable iff (ase_reset)
      soft_reset |=> (error_code == '0))
   else begin
      fail_count++;
      $error("error_code not cleared after soft reset");
   end

endmodule

bind ccip_sniffer ccip_sniffer_properties u_props (
   .clk        (clk),
   .ase_reset  (ase_reset),
   .soft_reset (soft_reset),
   .c0_tx      (c0_tx),
   .c1_tx      (c1_tx),
   .c0_full    (c0_full),
   .c1_full    (c1_full),
   .error_code (error_code)
);

//--- verification/tb_ccip_sniffer.sv
// CCI-P checker testbench
`timescale 1ns/10ps

module tb_ccip_sniffer;

   localparam int W = ccip_check_pkg::SNIFF_VECTOR_W;
   // Stimulus runs about 200 cycles
   localparam int MAX_CYCLES = 600;

   logic                      clk = 1'b0;
   logic                      ase_reset;
   logic                      soft_reset;
   ccip_check_pkg::c0_req_t   c0_tx;
   ccip_check_pkg::c1_req_t   c1_tx;
   logic                      c0_full;
   logic                      c1_full;
   ccip_check_pkg::mmio_evt_t mmio_req;
   ccip_check_pkg::mmio_evt_t mmio_rsp;
   logic [W-1:0]              error_code;

   integer      seed = 32'hfe30cd34;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [41:0] base;

   ccip_sniffer DUT (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_tx      (c0_tx),
      .c1_tx      (c1_tx),
      .c0_full    (c0_full),
      .c1_full    (c1_full),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .error_code (error_code)
   );

   always #10 clk = ~clk;

   // Hard stop if the stimulus hangs
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("Run stopped at the %0d cycle limit before the stimulus ended", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [W-1:0] code_mask(input ccip_check_pkg::sniff_code_e code);
      return W'(1) << code;
   endfunction

   // Random nonzero line address, 4-line aligned
   function automatic logic [41:0] rand_line();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return {r[41:3], 1'b1, 2'b00};
   endfunction

   function automatic ccip_check_pkg::c0_req_t read_req(input logic [3:0] op,
         input ccip_check_pkg::cl_len_e len, input logic [41:0] addr);
      ccip_check_pkg::c0_req_t r;
      r          = '0;
      r.valid    = 1'b1;
      r.req_type = ccip_check_pkg::c0_req_e'(op);
      r.cl_len   = len;
      r.address  = addr;
      r.mdata    = 16'h00c0;
      return r;
   endfunction

   function automatic ccip_check_pkg::c1_req_t write_beat(input logic [3:0] op,
         input ccip_check_pkg::cl_len_e len, input logic sop, input logic [41:0] addr,
         input logic [1:0] vc, input logic [15:0] mdata);
      ccip_check_pkg::c1_req_t r;
      r          = '0;
      r.valid    = 1'b1;
      r.req_type = ccip_check_pkg::c1_req_e'(op);
      r.cl_len   = len;
      r.sop      = sop;
      r.address  = addr;
      r.vc_sel   = vc;
      r.mdata    = mdata;
      return r;
   endfunction

   task automatic compare_code(input logic [W-1:0] expected);
      checks++;
      assert (error_code === expected) else begin
         errors++;
         $display("ERR %0t error_code expected %h got %h", $time, expected, error_code);
      end
   endtask

   // Back to idle, then look at the registered flags
   task automatic idle_and_check(input logic [W-1:0] expected);
      @(posedge clk);
      c0_tx      <= '0;
      c1_tx      <= '0;
      c0_full    <= 1'b0;
      c1_full    <= 1'b0;
      mmio_req   <= '0;
      mmio_rsp   <= '0;
      soft_reset <= 1'b0;
      @(negedge clk);
      compare_code(expected);
   endtask

   task automatic push_read(input ccip_check_pkg::c0_req_t req, input logic full,
         input logic [W-1:0] expected);
      @(posedge clk);
      c0_tx   <= req;
      c0_full <= full;
      idle_and_check(expected);
   endtask

   task automatic drive_write(input ccip_check_pkg::c1_req_t beat, input logic full,
         input logic [W-1:0] expected);
      @(posedge clk);
      c1_tx   <= beat;
      c1_full <= full;
      idle_and_check(expected);
   endtask

   task automatic mmio_event(input logic is_rsp, input logic [3:0] tid,
         input logic [W-1:0] expected);
      @(posedge clk);
      if (is_rsp) begin
         mmio_rsp <= {1'b1, tid};
      end else begin
         mmio_req <= {1'b1, tid};
      end
      idle_and_check(expected);
   endtask

   // Clean burst, sop only on the first beat
   task automatic legal_burst(input ccip_check_pkg::cl_len_e len, input logic [15:0] mdata);
      int beats;
      beats = (len == ccip_check_pkg::CL_LEN_4) ? 4 : 2;
      for (int i = 0; i < beats; i++) begin
         drive_write(write_beat(ccip_check_pkg::REQ_WRLINE_M, len, i == 0, base + 42'(i),
                                2'd1, mdata), 1'b0, '0);
      end
   endtask

   // Good first beat of a 2-line burst, then the given second beat
   task automatic second_beat_case(input ccip_check_pkg::c1_req_t beat2,
         input logic [W-1:0] expected);
      drive_write(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_2, 1'b1,
                             base, 2'd0, 16'h1234), 1'b0, '0);
      drive_write(beat2, 1'b0, expected);
   endtask

   initial begin
      ccip_check_pkg::c1_req_t fence;
      ase_reset  = 1'b1;
      soft_reset = 1'b0;
      c0_tx      = '0;
      c1_tx      = '0;
      c0_full    = 1'b0;
      c1_full    = 1'b0;
      mmio_req   = '0;
      mmio_rsp   = '0;
      repeat (4) @(posedge clk);
      ase_reset <= 1'b0;
      repeat (2) @(negedge clk) compare_code('0);

      // Channel 0 reads
      base = rand_line();
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_1, base), 1'b0, '0);
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_S, ccip_check_pkg::CL_LEN_2, base), 1'b0, '0);
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_4, base), 1'b0, '0);
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_3, base), 1'b0,
                code_mask(ccip_check_pkg::C0TX_3CL_REQUEST));
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_2, base | 42'd1),
                1'b0, code_mask(ccip_check_pkg::C0TX_ADDRALIGN_2));
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_S, ccip_check_pkg::CL_LEN_4, base | 42'd2),
                1'b0, code_mask(ccip_check_pkg::C0TX_ADDRALIGN_4));
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_1, '0), 1'b0,
                code_mask(ccip_check_pkg::C0TX_ADDR_ZERO_WARN));
      push_read(read_req(4'h5, ccip_check_pkg::CL_LEN_1, base), 1'b0,
                code_mask(ccip_check_pkg::C0TX_INVALID_REQTYPE));
      push_read(read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_1, base), 1'b1,
                code_mask(ccip_check_pkg::C0TX_OVERFLOW));

      // Soft reset hides a violation in the same cycle
      @(posedge clk);
      c0_tx      <= read_req(ccip_check_pkg::REQ_RDLINE_I, ccip_check_pkg::CL_LEN_1, base);
      c0_full    <= 1'b1;
      soft_reset <= 1'b1;
      idle_and_check('0);

      // Channel 1 bursts
      base = rand_line();
      legal_burst(ccip_check_pkg::CL_LEN_2, 16'h0a0a);
      legal_burst(ccip_check_pkg::CL_LEN_4, 16'h0b0b);
      drive_write(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_1, 1'b0, base,
                             2'd0, 16'h0), 1'b0, code_mask(ccip_check_pkg::C1TX_SOP_NOT_SET));
      drive_write(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_1, 1'b1, base,
                             2'd0, 16'h0), 1'b1, code_mask(ccip_check_pkg::C1TX_OVERFLOW));
      second_beat_case(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_2, 1'b1,
                                  base + 42'd1, 2'd0, 16'h1234),
                       code_mask(ccip_check_pkg::C1TX_SOP_SET_MCL));
      // Address must step by one line
      second_beat_case(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_2, 1'b0,
                                  base, 2'd0, 16'h1234),
                       code_mask(ccip_check_pkg::C1TX_UNEXP_ADDR));
      second_beat_case(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_2, 1'b0,
                                  base + 42'd1, 2'd3, 16'h1234),
                       code_mask(ccip_check_pkg::C1TX_UNEXP_VCSEL));
      second_beat_case(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_4, 1'b0,
                                  base + 42'd1, 2'd0, 16'h1234),
                       code_mask(ccip_check_pkg::C1TX_UNEXP_CLLEN));
      second_beat_case(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_2, 1'b0,
                                  base + 42'd1, 2'd0, 16'h4321),
                       code_mask(ccip_check_pkg::C1TX_UNEXP_MDATA));

      // Fences between bursts and inside one
      fence = write_beat(ccip_check_pkg::REQ_WRFENCE, ccip_check_pkg::CL_LEN_1, 1'b0, '0,
                         2'd0, 16'h0);
      drive_write(fence, 1'b0, '0);
      for (int i = 0; i < 4; i++) begin
         drive_write(write_beat(ccip_check_pkg::REQ_WRLINE_I, ccip_check_pkg::CL_LEN_4, i == 0,
                                base + 42'(i), 2'd2, 16'h4444), 1'b0, '0);
         if (i == 0) begin
            drive_write(fence, 1'b0, code_mask(ccip_check_pkg::C1TX_WRFENCE_IN_MCL));
         end
      end

      // MMIO answered in time, then unsolicited
      mmio_event(1'b0, 4'd3, '0);
      mmio_event(1'b1, 4'd3, '0);
      mmio_event(1'b1, 4'd7, code_mask(ccip_check_pkg::MMIO_RDRSP_UNSOLICITED));

      // Unanswered request, flag rises TIMEOUT+2 cycles after it
      @(posedge clk);
      mmio_req <= {1'b1, 4'd9};
      @(posedge clk);
      mmio_req <= '0;
      repeat (ccip_check_pkg::MMIO_RSP_TIMEOUT) @(posedge clk);
      @(negedge clk);
      compare_code('0);
      @(negedge clk);
      compare_code(code_mask(ccip_check_pkg::MMIO_RDRSP_TIMEOUT));
      // Late answer, flag lingers one cycle
      mmio_event(1'b1, 4'd9, code_mask(ccip_check_pkg::MMIO_RDRSP_TIMEOUT));
      @(negedge clk);
      compare_code('0);

      repeat (2) @(posedge clk);
      $display("Checks %0d, testbench errors %0d, assertion failures %0d",
               checks, errors, DUT.u_props.fail_count);
      if (errors == 0 && DUT.u_props.fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
